/* Bender.yml */
package:
  name: vcol_filter

sources:
  - logic/pixel_pkg.sv
  - logic/window_pkg.sv
  - logic/line_buffer.sv
  - logic/row_buffer_stack.sv
  - logic/column_box_sum.sv
  - logic/vcol_filter_top.sv
  - target: test
    files:
      - test/vcol_filter_sva.sv
      - test/tb_vcol_filter.sv

/* logic/column_box_sum.sv */
module column_box_sum (
    input  logic                            clk,
    input  logic                            rst_n,
    input  pixel_pkg::pixel_t               tap0_i,
    input  pixel_pkg::pixel_t               tap1_i,
    input  pixel_pkg::pixel_t               tap2_i,
    input  pixel_pkg::pixel_t               tap3_i,
    input  pixel_pkg::pixel_t               tap4_i,
    input  pixel_pkg::pixel_t               tap5_i,
    input  pixel_pkg::pixel_t               tap6_i,
    input  pixel_pkg::pixel_t               tap7_i,
    input  pixel_pkg::pixel_t               tap8_i,
    input  pixel_pkg::pixel_t               tap9_i,
    input  pixel_pkg::pixel_t               tap10_i,
    input  pixel_pkg::pixel_t               tap11_i,
    input  pixel_pkg::pixel_t               tap12_i,
    input  logic [window_pkg::NUM_TAPS-1:0] tap_valid_i,
    output pixel_pkg::sum_r2_t              sum_r2_o,
    output pixel_pkg::sum_r4_t              sum_r4_o,
    output pixel_pkg::sum_r6_t              sum_r6_o,
    output logic                            sum_valid_o
);
    import pixel_pkg::*;
    import window_pkg::*;

    pixel_t  tap_raw [NUM_TAPS];
    pixel_t  tap_m   [NUM_TAPS];
    sum_r2_t part_s;
    sum_r4_t part_m;
    sum_r6_t part_l;

    assign tap_raw = '{tap0_i, tap1_i, tap2_i, tap3_i, tap4_i, tap5_i, tap6_i,
                       tap7_i, tap8_i, tap9_i, tap10_i, tap11_i, tap12_i};

    // Rows without a valid pixel add nothing
    always_comb begin
        for (int k = 0; k < NUM_TAPS; k++) begin
            tap_m[k] = tap_valid_i[k] ? tap_raw[k] : '0;
        end
    end

    // ********************
    // Nested windows that each add a ring to the last
    // ********************

    always_comb begin
        part_s = '0;
        for (int k = CENTER_TAP - RADIUS_S; k <= CENTER_TAP + RADIUS_S; k++) begin
            part_s = part_s + sum_r2_t'(tap_m[k]);
        end
    end

    always_comb begin
        part_m = sum_r4_t'(part_s);
        for (int d = RADIUS_S + 1; d <= RADIUS_M; d++) begin
            part_m = part_m + sum_r4_t'(tap_m[CENTER_TAP-d]) + sum_r4_t'(tap_m[CENTER_TAP+d]);
        end
    end

    always_comb begin
        part_l = sum_r6_t'(part_m);
        for (int d = RADIUS_M + 1; d <= RADIUS_L; d++) begin
            part_l = part_l + sum_r6_t'(tap_m[CENTER_TAP-d]) + sum_r6_t'(tap_m[CENTER_TAP+d]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_r2_o    <= '0;
            sum_r4_o    <= '0;
            sum_r6_o    <= '0;
            sum_valid_o <= 1'b0;
        end else begin
            sum_r2_o    <= part_s;
            sum_r4_o    <= part_m;
            sum_r6_o    <= part_l;
            sum_valid_o <= tap_valid_i[CENTER_TAP];
        end
    end

endmodule

/* logic/line_buffer.sv */
module line_buffer #(
    parameter int LINE_W = 640
) (
    input  logic              clk,
    input  logic              rst_n,
    input  pixel_pkg::pixel_t pix_i,
    input  logic              valid_i,
    input  logic              done_i,
    output pixel_pkg::pixel_t pix_o,
    output logic              valid_o,
    output logic              done_o
);
    import pixel_pkg::*;

    localparam int PTR_W = (LINE_W > 1) ? $clog2(LINE_W) : 1;

    pixel_t            mem [LINE_W];
    logic [LINE_W-1:0] valid_q;
    logic [LINE_W-1:0] done_q;
    logic [PTR_W-1:0]  ptr_q;

    // Oldest entry sits under the pointer
    assign pix_o   = mem[ptr_q];
    assign valid_o = valid_q[ptr_q];
    assign done_o  = done_q[ptr_q];

    always_ff @(posedge clk) begin
        mem[ptr_q] <= pix_i;
    end

    // Tags share the pointer with the pixel memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q   <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            valid_q[ptr_q] <= valid_i;
            done_q[ptr_q]  <= done_i;
            if (ptr_q == PTR_W'(LINE_W - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

endmodule

/* logic/pixel_pkg.sv */
package pixel_pkg;

    // ********************
    // Pixel
    // ********************

    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pixel_t;

    // ********************
    // Column sums
    // ********************

    // Sized for a full window of 255 pixels
    localparam int SUM_R2_W = 11;
    localparam int SUM_R4_W = 12;
    localparam int SUM_R6_W = 12;

    typedef logic [SUM_R2_W-1:0] sum_r2_t;
    typedef logic [SUM_R4_W-1:0] sum_r4_t;
    typedef logic [SUM_R6_W-1:0] sum_r6_t;

endpackage

/* logic/row_buffer_stack.sv */
module row_buffer_stack #(
    parameter int LINE_W = 640
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  pixel_pkg::pixel_t                 pix_i,
    input  logic                              pix_valid_i,
    input  logic                              done_i,
    output pixel_pkg::pixel_t                 tap0_o,
    output pixel_pkg::pixel_t                 tap1_o,
    output pixel_pkg::pixel_t                 tap2_o,
    output pixel_pkg::pixel_t                 tap3_o,
    output pixel_pkg::pixel_t                 tap4_o,
    output pixel_pkg::pixel_t                 tap5_o,
    output pixel_pkg::pixel_t                 tap6_o,
    output pixel_pkg::pixel_t                 tap7_o,
    output pixel_pkg::pixel_t                 tap8_o,
    output pixel_pkg::pixel_t                 tap9_o,
    output pixel_pkg::pixel_t                 tap10_o,
    output pixel_pkg::pixel_t                 tap11_o,
    output pixel_pkg::pixel_t                 tap12_o,
    output logic [window_pkg::NUM_TAPS-1:0]   tap_valid_o,
    output logic                              done_r2_o,
    output logic                              done_r4_o,
    output logic                              done_r6_o
);
    import pixel_pkg::*;
    import window_pkg::*;

    // Index k of each chain is tap k
    wire pixel_t              chain_pix [NUM_TAPS];
    wire [NUM_TAPS-1:0]       chain_valid;
    wire [NUM_TAPS-1:0]       chain_done;

    assign chain_pix[0]   = pix_i;
    assign chain_valid[0] = pix_valid_i;
    assign chain_done[0]  = done_i;

    for (genvar i = 0; i < NUM_LINES; i++) begin : gen_lines
        line_buffer #(
            .LINE_W (LINE_W)
        ) u_line_buffer (
            .clk     (clk),
            .rst_n   (rst_n),
            .pix_i   (chain_pix[i]),
            .valid_i (chain_valid[i]),
            .done_i  (chain_done[i]),
            .pix_o   (chain_pix[i+1]),
            .valid_o (chain_valid[i+1]),
            .done_o  (chain_done[i+1])
        );
    end

    assign tap0_o  = chain_pix[0];
    assign tap1_o  = chain_pix[1];
    assign tap2_o  = chain_pix[2];
    assign tap3_o  = chain_pix[3];
    assign tap4_o  = chain_pix[4];
    assign tap5_o  = chain_pix[5];
    assign tap6_o  = chain_pix[6];
    assign tap7_o  = chain_pix[7];
    assign tap8_o  = chain_pix[8];
    assign tap9_o  = chain_pix[9];
    assign tap10_o = chain_pix[10];
    assign tap11_o = chain_pix[11];
    assign tap12_o = chain_pix[12];

    assign tap_valid_o = chain_valid;

    // Done leaves once the last row of each window has passed
    assign done_r2_o = chain_done[2*RADIUS_S];
    assign done_r4_o = chain_done[2*RADIUS_M];
    assign done_r6_o = chain_done[2*RADIUS_L];

endmodule

/* logic/vcol_filter_top.sv */
module vcol_filter_top #(
    parameter int LINE_W = 640
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pix_valid_i,
    input  pixel_pkg::pixel_t  pix_i,
    input  logic               done_i,
    output pixel_pkg::sum_r2_t sum_r2_o,
    output pixel_pkg::sum_r4_t sum_r4_o,
    output pixel_pkg::sum_r6_t sum_r6_o,
    output logic               sum_valid_o,
    output logic               done_r2_o,
    output logic               done_r4_o,
    output logic               done_r6_o
);
    import pixel_pkg::*;
    import window_pkg::*;

    pixel_t tap0, tap1, tap2, tap3, tap4, tap5, tap6;
    pixel_t tap7, tap8, tap9, tap10, tap11, tap12;
    logic [NUM_TAPS-1:0] tap_valid;

    // ********************
    // Row delay taps
    // ********************

    row_buffer_stack #(
        .LINE_W (LINE_W)
    ) u_row_buffer_stack (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .done_i      (done_i),
        .tap0_o      (tap0),
        .tap1_o      (tap1),
        .tap2_o      (tap2),
        .tap3_o      (tap3),
        .tap4_o      (tap4),
        .tap5_o      (tap5),
        .tap6_o      (tap6),
        .tap7_o      (tap7),
        .tap8_o      (tap8),
        .tap9_o      (tap9),
        .tap10_o     (tap10),
        .tap11_o     (tap11),
        .tap12_o     (tap12),
        .tap_valid_o (tap_valid),
        .done_r2_o   (done_r2_o),
        .done_r4_o   (done_r4_o),
        .done_r6_o   (done_r6_o)
    );

    // ********************
    // Column sums
    // ********************

    column_box_sum u_column_box_sum (
        .clk         (clk),
        .rst_n       (rst_n),
        .tap0_i      (tap0),
        .tap1_i      (tap1),
        .tap2_i      (tap2),
        .tap3_i      (tap3),
        .tap4_i      (tap4),
        .tap5_i      (tap5),
        .tap6_i      (tap6),
        .tap7_i      (tap7),
        .tap8_i      (tap8),
        .tap9_i      (tap9),
        .tap10_i     (tap10),
        .tap11_i     (tap11),
        .tap12_i     (tap12),
        .tap_valid_i (tap_valid),
        .sum_r2_o    (sum_r2_o),
        .sum_r4_o    (sum_r4_o),
        .sum_r6_o    (sum_r6_o),
        .sum_valid_o (sum_valid_o)
    );

endmodule

/* logic/window_pkg.sv */
package window_pkg;

    // ********************
    // Line buffer stack
    // ********************

    localparam int NUM_LINES = 12;

    // Tap 0 is the live row, tap k is k rows back
    localparam int NUM_TAPS = NUM_LINES + 1;

    // ********************
    // Box windows
    // ********************

    localparam int CENTER_TAP = NUM_LINES / 2;

    // Window height is 2R+1 rows
    localparam int RADIUS_S = 2;
    localparam int RADIUS_M = 4;
    localparam int RADIUS_L = 6;

endpackage

/* test/tb_vcol_filter.sv */
module tb_vcol_filter;
    import pixel_pkg::*;

    localparam int LINE_W     = 8;
    localparam int TRACE_LEN  = 128;
    localparam int FIELDS     = 10;
    localparam int MAX_CYCLES = TRACE_LEN + 6 * LINE_W + 20;

    logic        clk;
    logic        rst_n;
    logic        pix_valid_i;
    pixel_t      pix_i;
    logic        done_i;
    sum_r2_t     sum_r2_o;
    sum_r4_t     sum_r4_o;
    sum_r6_t     sum_r6_o;
    logic        sum_valid_o;
    logic        done_r2_o;
    logic        done_r4_o;
    logic        done_r6_o;

    logic [11:0] trace_mem [TRACE_LEN*FIELDS];
    int          sum_errors;
    int          tag_errors;
    int          assert_errors;
    int          other_errors;
    int          cycle_count;
    int unsigned lead_in;

    vcol_filter_top #(
        .LINE_W (LINE_W)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .done_i      (done_i),
        .sum_r2_o    (sum_r2_o),
        .sum_r4_o    (sum_r4_o),
        .sum_r6_o    (sum_r6_o),
        .sum_valid_o (sum_valid_o),
        .done_r2_o   (done_r2_o),
        .done_r4_o   (done_r4_o),
        .done_r6_o   (done_r6_o)
    );

    bind vcol_filter_top vcol_filter_sva #(.LINE_W (LINE_W)) u_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_valid_i (pix_valid_i),
        .done_i      (done_i),
        .sum_valid_o (sum_valid_o),
        .done_r2_o   (done_r2_o),
        .done_r4_o   (done_r4_o),
        .done_r6_o   (done_r6_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ********************
    // Checking
    // ********************

    function automatic string behavior_name(input int line);
        int slot;
        slot = line / LINE_W;
        if (line < 0) begin
            return "reset_state";
        end else if (slot < 8) begin
            return "partial_window";
        end else if (slot == 8) begin
            return "idle_gap";
        end else if (slot < 15) begin
            return "mixed_window";
        end
        return "full_window_width";
    endfunction

    task automatic compare_value(input string name, input string what,
                                 input logic [11:0] expected, input logic [11:0] actual,
                                 input bit is_sum);
        assert (actual === expected) else begin
            if (is_sum) begin
                sum_errors++;
            end else begin
                tag_errors++;
            end
            $display("MISMATCH %s %s: expected %0d, actual %0d", name, what, expected, actual);
        end
    endtask

    // Line -1 is an idle cycle where every output must stay quiet
    task automatic check_outputs(input int line);
        string       name;
        logic [11:0] exp_val [7];
        name = behavior_name(line);
        for (int f = 0; f < 7; f++) begin
            exp_val[f] = (line < 0) ? 12'h000 : trace_mem[line*FIELDS+3+f];
        end
        compare_value(name, "sum_valid_o", exp_val[0], 12'(sum_valid_o), 1'b0);
        compare_value(name, "sum_r2_o", exp_val[1], 12'(sum_r2_o), 1'b1);
        compare_value(name, "sum_r4_o", exp_val[2], 12'(sum_r4_o), 1'b1);
        compare_value(name, "sum_r6_o", exp_val[3], 12'(sum_r6_o), 1'b1);
        compare_value("done_timing", "done_r2_o", exp_val[4], 12'(done_r2_o), 1'b0);
        compare_value("done_timing", "done_r4_o", exp_val[5], 12'(done_r4_o), 1'b0);
        compare_value("done_timing", "done_r6_o", exp_val[6], 12'(done_r6_o), 1'b0);
    endtask

    task automatic run_cycle(input int line);
        @(negedge clk);
        if (line < 0) begin
            pix_valid_i = 1'b0;
            done_i      = 1'b0;
            pix_i       = '0;
        end else begin
            pix_valid_i = trace_mem[line*FIELDS][0];
            done_i      = trace_mem[line*FIELDS+1][0];
            pix_i       = pixel_t'(trace_mem[line*FIELDS+2]);
        end
        @(posedge clk);
        #1;
        check_outputs(line);
    endtask

    // ********************
    // Run
    // ********************

    initial begin
        void'($urandom(32'h217a_7a22));
        sum_errors    = 0;
        tag_errors    = 0;
        assert_errors = 0;
        other_errors  = 0;
        rst_n         = 1'b0;
        pix_valid_i   = 1'b0;
        pix_i         = '0;
        done_i        = 1'b0;
        $readmemh("test/vcol_trace.hex", trace_mem);
        if ($isunknown(trace_mem[TRACE_LEN*FIELDS-1])) begin
            other_errors++;
            $display("Trace file test/vcol_trace.hex is missing or too short");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Idle lead-in of random length while the pipeline is empty
        lead_in = 1 + ($urandom % 4);
        repeat (lead_in) run_cycle(-1);
        for (int line = 0; line < TRACE_LEN; line++) begin
            run_cycle(line);
        end
        assert_errors = u_dut.u_sva.fail_count;
        $display("Errors: sum %0d, tag %0d, assertion %0d, other %0d",
                 sum_errors, tag_errors, assert_errors, other_errors);
        if (sum_errors + tag_errors + assert_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

/* test/vcol_filter_sva.sv */
module vcol_filter_sva #(
    parameter int LINE_W = 640
) (
    input logic clk,
    input logic rst_n,
    input logic pix_valid_i,
    input logic done_i,
    input logic sum_valid_o,
    input logic done_r2_o,
    input logic done_r4_o,
    input logic done_r6_o
);
    import window_pkg::*;

    localparam int DONE_S_LAT = 2 * RADIUS_S * LINE_W;
    localparam int SUM_LAT    = CENTER_TAP * LINE_W + 1;

    int unsigned fail_count = 0;

    // Done tag rides with its pixel through four rows
    a_done_r2_delay : assert property (@(posedge clk) disable iff (!rst_n)
        done_r2_o |-> $past(done_i, DONE_S_LAT))
        else begin
            $error("done_r2_o high without done_i %0d cycles earlier", DONE_S_LAT);
            fail_count++;
        end

    // Centre tag plus the output register
    a_sum_valid_delay : assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid_o |-> $past(pix_valid_i, SUM_LAT))
        else begin
            $error("sum_valid_o high without pix_valid_i %0d cycles earlier", SUM_LAT);
            fail_count++;
        end

    a_reset_quiet : assert property (@(posedge clk)
        $rose(rst_n) |=> !(sum_valid_o || done_r2_o || done_r4_o || done_r6_o))
        else begin
            $error("output strobe active right after reset release");
            fail_count++;
        end

endmodule

/* test/vcol_trace.hex */
// valid done pixel, then expected sum_valid r2 r4 r6 and done_r2 done_r4 done_r6
// one line per cycle, expected values seen after that cycle's rising edge
1 0 10 0 0 0 10 0 0 0
1 0 11 0 0 0 11 0 0 0
1 0 12 0 0 0 12 0 0 0
1 0 13 0 0 0 13 0 0 0
1 0 14 0 0 0 14 0 0 0
1 0 15 0 0 0 15 0 0 0
1 0 16 0 0 0 16 0 0 0
1 0 17 0 0 0 17 0 0 0
1 0 20 0 0 0 30 0 0 0
1 0 21 0 0 0 32 0 0 0
1 0 22 0 0 0 34 0 0 0
1 0 23 0 0 0 36 0 0 0
1 0 24 0 0 0 38 0 0 0
1 0 25 0 0 0 3A 0 0 0
1 0 26 0 0 0 3C 0 0 0
1 1 27 0 0 0 3E 0 0 0
0 0 00 0 0 10 30 0 0 0
0 0 00 0 0 11 32 0 0 0
0 0 00 0 0 12 34 0 0 0
0 0 00 0 0 13 36 0 0 0
0 0 00 0 0 14 38 0 0 0
0 0 00 0 0 15 3A 0 0 0
0 0 00 0 0 16 3C 0 0 0
0 0 00 0 0 17 3E 0 0 0
1 0 FF 0 0 30 12F 0 0 0
1 0 FD 0 0 32 12F 0 0 0
1 0 FB 0 0 34 12F 0 0 0
1 0 F9 0 0 36 12F 0 0 0
1 0 F7 0 0 38 12F 0 0 0
1 0 F5 0 0 3A 12F 0 0 0
1 0 F3 0 0 3C 12F 0 0 0
1 0 F1 0 0 3E 12F 0 0 0
1 0 FF 0 10 30 22E 0 0 0
1 0 FD 0 11 32 22C 0 0 0
1 0 FB 0 12 34 22A 0 0 0
1 0 F9 0 13 36 228 0 0 0
1 0 F7 0 14 38 226 0 0 0
1 0 F5 0 15 3A 224 0 0 0
1 0 F3 0 16 3C 222 0 0 0
1 0 F1 0 17 3E 220 0 0 0
1 0 FF 0 30 12F 32D 0 0 0
1 0 FD 0 32 12F 329 0 0 0
1 0 FB 0 34 12F 325 0 0 0
1 0 F9 0 36 12F 321 0 0 0
1 0 F7 0 38 12F 31D 0 0 0
1 0 F5 0 3A 12F 319 0 0 0
1 0 F3 0 3C 12F 315 1 0 0
1 0 F1 0 3E 12F 311 0 0 0
1 0 FF 1 30 22E 42C 0 0 0
1 0 FD 1 32 22C 426 0 0 0
1 0 FB 1 34 22A 420 0 0 0
1 0 F9 1 36 228 41A 0 0 0
1 0 F7 1 38 226 414 0 0 0
1 0 F5 1 3A 224 40E 0 0 0
1 0 F3 1 3C 222 408 0 0 0
1 0 F1 1 3E 220 402 0 0 0
1 0 FF 1 12F 32D 52B 0 0 0
1 0 FD 1 12F 329 523 0 0 0
1 0 FB 1 12F 325 51B 0 0 0
1 0 F9 1 12F 321 513 0 0 0
1 0 F7 1 12F 31D 50B 0 0 0
1 0 F5 1 12F 319 503 0 0 0
1 0 F3 1 12F 315 4FB 0 0 0
1 0 F1 1 12F 311 4F3 0 0 0
1 0 FF 0 22E 42C 62A 0 0 0
1 0 FD 0 22C 426 620 0 0 0
1 0 FB 0 22A 420 616 0 0 0
1 0 F9 0 228 41A 60C 0 0 0
1 0 F7 0 226 414 602 0 0 0
1 0 F5 0 224 40E 5F8 0 0 0
1 0 F3 0 222 408 5EE 0 0 0
1 0 F1 0 220 402 5E4 0 0 0
1 0 FF 1 31D 52B 729 0 0 0
1 0 FD 1 318 523 71D 0 0 0
1 0 FB 1 313 51B 711 0 0 0
1 0 F9 1 30E 513 705 0 0 0
1 0 F7 1 309 50B 6F9 0 0 0
1 0 F5 1 304 503 6ED 0 0 0
1 0 F3 1 2FF 4FB 6E1 0 1 0
1 0 F1 1 2FA 4F3 6D5 0 0 0
1 0 FF 1 3FC 62A 828 0 0 0
1 0 FD 1 3F4 620 81A 0 0 0
1 0 FB 1 3EC 616 80C 0 0 0
1 0 F9 1 3E4 60C 7FE 0 0 0
1 0 F7 1 3DC 602 7F0 0 0 0
1 0 F5 1 3D4 5F8 7E2 0 0 0
1 0 F3 1 3CC 5EE 7D4 0 0 0
1 0 F1 1 3C4 5E4 7C6 0 0 0
1 0 FF 1 4FB 719 927 0 0 0
1 0 FD 1 4F1 70C 917 0 0 0
1 0 FB 1 4E7 6FF 907 0 0 0
1 0 F9 1 4DD 6F2 8F7 0 0 0
1 0 F7 1 4D3 6E5 8E7 0 0 0
1 0 F5 1 4C9 6D8 8D7 0 0 0
1 0 F3 1 4BF 6CB 8C7 0 0 0
1 0 F1 1 4B5 6BE 8B7 0 0 0
1 0 FF 1 4FB 7F8 A26 0 0 0
1 0 FD 1 4F1 7E8 A14 0 0 0
1 0 FB 1 4E7 7D8 A02 0 0 0
1 0 F9 1 4DD 7C8 9F0 0 0 0
1 0 F7 1 4D3 7B8 9DE 0 0 0
1 0 F5 1 4C9 7A8 9CC 0 0 0
1 0 F3 1 4BF 798 9BA 0 0 0
1 0 F1 1 4B5 788 9A8 0 0 0
1 0 FF 1 4FB 8F7 B15 0 0 0
1 0 FD 1 4F1 8E5 B00 0 0 0
1 0 FB 1 4E7 8D3 AEB 0 0 0
1 0 F9 1 4DD 8C1 AD6 0 0 0
1 0 F7 1 4D3 8AF AC1 0 0 0
1 0 F5 1 4C9 89D AAC 0 0 0
1 0 F3 1 4BF 88B A97 0 0 1
1 0 F1 1 4B5 879 A82 0 0 0
1 0 FF 1 4FB 8F7 BF4 0 0 0
1 0 FD 1 4F1 8E5 BDC 0 0 0
1 0 FB 1 4E7 8D3 BC4 0 0 0
1 0 F9 1 4DD 8C1 BAC 0 0 0
1 0 F7 1 4D3 8AF B94 0 0 0
1 0 F5 1 4C9 89D B7C 0 0 0
1 0 F3 1 4BF 88B B64 0 0 0
1 0 F1 1 4B5 879 B4C 0 0 0
1 0 FF 1 4FB 8F7 CF3 0 0 0
1 0 FD 1 4F1 8E5 CD9 0 0 0
1 0 FB 1 4E7 8D3 CBF 0 0 0
1 0 F9 1 4DD 8C1 CA5 0 0 0
1 0 F7 1 4D3 8AF C8B 0 0 0
1 0 F5 1 4C9 89D C71 0 0 0
1 0 F3 1 4BF 88B C57 0 0 0
1 1 F1 1 4B5 879 C3D 0 0 0

/* vcol_filter.f */
logic/pixel_pkg.sv
logic/window_pkg.sv
logic/line_buffer.sv
logic/row_buffer_stack.sv
logic/column_box_sum.sv
logic/vcol_filter_top.sv
test/vcol_filter_sva.sv
test/tb_vcol_filter.sv
